/* mem/boot.hex */
// One 32-bit word per line in hex, first line is the word at the ROM base address
00001137
80000237
0040006f
deadbeef
01234567
89abcdef
a5a55a5a
0f1e2d3c
4b5a6978
87968574
cafef00d
13579bdf
2468ace0
fedcba98
7f00ff01
c0ffee11

/* sim.f */
common/dbg_pkg.sv
dm/dm_addr_counter.sv
dm/dm_sba_fsm.sv
mem/boot_rom.sv
mem/sram.sv
mem/mem_xbar.sv
src/dbg_harness.sv
testbench/tb_dbg_harness.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= sim.f
TB_TOP    ?= tb_dbg_harness
RTL_TOP   ?= dbg_harness
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= TEST PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_dbg_harness.sv */
// Run from the project root so mem/boot.hex is found; SRAM reads only touch bytes written first
`timescale 1ns/100ps
`default_nettype none

module tb_dbg_harness import dbg_pkg::*; ();

    localparam int          RESET_CYCLES = 16;
    localparam int          N_RAND       = 40;
    localparam int          N_BP         = 8;
    localparam int          NUM_TXN      = 93 + 4 * N_RAND;
    localparam logic [31:0] RAND_BASE    = SRAM_BASE + 32'h100;

    logic      clk = 1'b0;
    logic      arst_n;
    dmi_req_t  dmi_req;
    logic      dmi_req_valid;
    logic      dmi_req_ready;
    dmi_resp_t dmi_resp;
    logic      dmi_resp_valid;
    logic      dmi_resp_ready;

    // Reference model state
    logic [1:0]  sbcs_sh;
    logic [31:0] sbaddr_sh;
    logic [31:0] rom_img [ROM_WORDS];
    logic [7:0]  sram_sh [SRAM_WORDS * 4];

    dmi_resp_t exp_q [$];
    logic      held = 1'b0;
    dmi_resp_t held_resp;
    int        seed = 23211;

    always #5 clk = ~clk;

    dbg_harness uut (
        .clk_i            ( clk            ),
        .arst_n_i         ( arst_n         ),
        .dmi_req_i        ( dmi_req        ),
        .dmi_req_valid_i  ( dmi_req_valid  ),
        .dmi_req_ready_o  ( dmi_req_ready  ),
        .dmi_resp_o       ( dmi_resp       ),
        .dmi_resp_valid_o ( dmi_resp_valid ),
        .dmi_resp_ready_i ( dmi_resp_ready )
    );

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic int size_bytes(logic [1:0] size);
        case (size)
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic is_aligned(logic [31:0] a, logic [1:0] size);
        return (a % size_bytes(size)) == 0;
    endfunction

    function automatic logic in_rom(logic [31:0] a);
        return (a >= ROM_BASE) && (a < ROM_BASE + ROM_WORDS * 4);
    endfunction

    function automatic logic in_sram(logic [31:0] a);
        return (a >= SRAM_BASE) && (a < SRAM_BASE + SRAM_WORDS * 4);
    endfunction

    function automatic logic [7:0] read_byte(logic [31:0] a);
        logic [31:0] w;
        if (in_rom(a)) begin
            w = rom_img[a[5:2]];
            return 8'(w >> {a[1:0], 3'b000});
        end
        return sram_sh[a[9:0]];
    endfunction

    // Cycles from acceptance to response valid
    function automatic int exp_latency(dmi_req_t req);
        if ((req.op == READ || req.op == WRITE) && req.addr == DM_SBDATA_ADDR
            && is_aligned(sbaddr_sh, sbcs_sh))
            return 3;
        return 1;
    endfunction

    function automatic dmi_resp_t ref_resp(dmi_req_t req);
        dmi_resp_t   r;
        logic [31:0] b;
        int          n;
        r.resp = SUCCESS;
        r.data = '0;
        n = size_bytes(sbcs_sh);
        if (req.op == READ || req.op == WRITE) begin
            case (req.addr)
                DM_SBCS_ADDR: begin
                    if (req.op == WRITE)
                        sbcs_sh = req.data[1:0];
                    else
                        r.data = {30'h0, sbcs_sh};
                end
                DM_SBADDR_ADDR: begin
                    if (req.op == WRITE)
                        sbaddr_sh = req.data;
                    else
                        r.data = sbaddr_sh;
                end
                DM_SBDATA_ADDR: begin
                    if (!is_aligned(sbaddr_sh, sbcs_sh)
                        || !(in_rom(sbaddr_sh) || in_sram(sbaddr_sh))
                        || (in_rom(sbaddr_sh) && req.op == WRITE)) begin
                        r.resp = FAILED;
                    end else begin
                        // Little endian with byte i of the access at address + i
                        for (int i = 0; i < n; i++) begin
                            b = sbaddr_sh + 32'(i);
                            if (req.op == WRITE)
                                sram_sh[b[9:0]] = 8'(req.data >> (8 * i));
                            else
                                r.data = r.data | ({24'h0, read_byte(b)} << (8 * i));
                        end
                        sbaddr_sh = sbaddr_sh + 32'(n);
                    end
                end
                default: r.resp = FAILED;
            endcase
        end
        return r;
    endfunction

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_resp(string name, dmi_resp_t got, dmi_resp_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_ready(logic got, logic exp);
        if (got !== exp) begin
            $display("Fail dmi_req_ready_o: got 0x%h, expected 0x%h", got, exp);
            fail_run();
        end
    endtask

    // Compares every response taken and its stability under back-pressure
    always @(posedge clk) begin
        if (dmi_resp_valid) begin
            check_ready(dmi_req_ready, 1'b0);
            if (held)
                check_resp("dmi_resp_o", dmi_resp, held_resp);
            if (dmi_resp_ready) begin
                held = 1'b0;
                if (exp_q.size() == 0) begin
                    $display("A response arrived with no request outstanding");
                    fail_run();
                end else begin
                    check_resp("dmi_resp_o", dmi_resp, exp_q.pop_front());
                end
            end else begin
                held      = 1'b1;
                held_resp = dmi_resp;
            end
        end else if (held) begin
            $display("Response valid dropped before the response was taken");
            fail_run();
        end
    end

    // ----------------------------------------------------------
    // DMI driver
    // ----------------------------------------------------------
    task automatic dmi_access(dmi_op_e op, logic [6:0] addr, logic [31:0] data, int hold);
        dmi_req_t req;
        int       lat;
        int       cycles;
        req.addr = addr;
        req.op   = op;
        req.data = data;
        dmi_req       <= req;
        dmi_req_valid <= 1'b1;
        do @(posedge clk); while (!dmi_req_ready);
        // Accepted on this edge
        lat = exp_latency(req);
        exp_q.push_back(ref_resp(req));
        dmi_req_valid <= 1'b0;
        if (hold > 0)
            dmi_resp_ready <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!dmi_resp_valid);
        if (cycles != lat) begin
            $display("Response valid came %0d cycles after acceptance, %0d expected", cycles, lat);
            fail_run();
        end
        if (hold > 0) begin
            repeat (hold - 1) @(posedge clk);
            dmi_resp_ready <= 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic write_reg(logic [6:0] addr, logic [31:0] data);
        dmi_access(WRITE, addr, data, 0);
    endtask

    task automatic read_reg(logic [6:0] addr);
        dmi_access(READ, addr, 32'h0, 0);
    endtask

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin
        int          r;
        int          hold;
        logic [31:0] off;
        sb_size_e    sz;
        $readmemh("mem/boot.hex", rom_img);
        sbcs_sh        = 2'd2;
        sbaddr_sh      = '0;
        arst_n         <= 1'b0;
        dmi_req        <= '0;
        dmi_req_valid  <= 1'b0;
        dmi_resp_ready <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        // Reset state
        check_ready(dmi_req_ready, 1'b1);
        if (dmi_resp_valid !== 1'b0) begin
            $display("Fail dmi_resp_valid_o: got 0x%h, expected 0x0", dmi_resp_valid);
            fail_run();
        end
        read_reg(DM_SBCS_ADDR);
        read_reg(DM_SBADDR_ADDR);

        // Register write and read back with SBCS masked to two bits
        write_reg(DM_SBCS_ADDR, 32'hDEAD_BEE5);
        read_reg(DM_SBCS_ADDR);
        write_reg(DM_SBCS_ADDR, 32'h0000_0010);
        read_reg(DM_SBCS_ADDR);
        write_reg(DM_SBADDR_ADDR, 32'h1234_5678);
        read_reg(DM_SBADDR_ADDR);
        write_reg(DM_SBCS_ADDR, 32'd2);

        // ROM walk with auto-increment
        write_reg(DM_SBADDR_ADDR, ROM_BASE);
        for (int i = 0; i < ROM_WORDS; i++)
            read_reg(DM_SBDATA_ADDR);
        read_reg(DM_SBADDR_ADDR);

        // Fill the SRAM window before random sized accesses inside it
        write_reg(DM_SBCS_ADDR, 32'd2);
        write_reg(DM_SBADDR_ADDR, RAND_BASE);
        for (int i = 0; i < 32; i++)
            dmi_access(WRITE, DM_SBDATA_ADDR, $random(seed), 0);
        for (int n = 0; n < N_RAND; n++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    sz = BYTE;
                2'd1:    sz = HALF;
                default: sz = WORD;
            endcase
            off = {25'h0, r[8:2]};
            off = off & ~(32'(size_bytes(sz)) - 32'd1);
            write_reg(DM_SBCS_ADDR, {30'h0, sz});
            write_reg(DM_SBADDR_ADDR, RAND_BASE + off);
            if (r[9])
                dmi_access(WRITE, DM_SBDATA_ADDR, $random(seed), 0);
            else
                dmi_access(READ, DM_SBDATA_ADDR, $random(seed), 0);
            read_reg(DM_SBADDR_ADDR);
        end

        // Error cases that must leave SBADDRESS where it is
        write_reg(DM_SBCS_ADDR, 32'd1);
        write_reg(DM_SBADDR_ADDR, RAND_BASE + 32'd1);
        read_reg(DM_SBDATA_ADDR);
        read_reg(DM_SBADDR_ADDR);
        write_reg(DM_SBCS_ADDR, 32'd2);
        write_reg(DM_SBADDR_ADDR, RAND_BASE + 32'd2);
        write_reg(DM_SBDATA_ADDR, 32'h5555_AAAA);
        read_reg(DM_SBADDR_ADDR);
        write_reg(DM_SBADDR_ADDR, 32'h4000_0000);
        read_reg(DM_SBDATA_ADDR);
        read_reg(DM_SBADDR_ADDR);
        write_reg(DM_SBADDR_ADDR, ROM_BASE + ROM_WORDS * 4);
        read_reg(DM_SBDATA_ADDR);
        read_reg(DM_SBADDR_ADDR);
        write_reg(DM_SBADDR_ADDR, ROM_BASE + 32'd8);
        write_reg(DM_SBDATA_ADDR, 32'hFFFF_FFFF);
        read_reg(DM_SBADDR_ADDR);
        read_reg(DM_SBDATA_ADDR);
        read_reg(7'h10);
        write_reg(7'h11, 32'h1);
        read_reg(DM_SBADDR_ADDR);
        dmi_access(NOP, DM_SBDATA_ADDR, 32'hFFFF_FFFF, 0);

        // Back-pressure on the response channel
        write_reg(DM_SBCS_ADDR, 32'd2);
        write_reg(DM_SBADDR_ADDR, RAND_BASE);
        for (int n = 0; n < N_BP; n++) begin
            r    = $random(seed);
            hold = 1 + (r & 7);
            dmi_access(READ, DM_SBDATA_ADDR, 32'h0, hold);
        end

        repeat (2) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived", exp_q.size());
            fail_run();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    // Budget of 20 cycles per planned transaction
    initial begin
        repeat (RESET_CYCLES + NUM_TXN * 20) @(posedge clk);
        $display("Timeout, the DUT stopped responding on the DMI channel");
        fail_run();
    end

endmodule

`default_nettype wire

/* src/dbg_harness.sv */
// Fixed map: boot ROM at 0x1000 and SRAM at 0x8000_0000, nothing else decoded
`timescale 1ns/100ps
`default_nettype none

module dbg_harness import dbg_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire dmi_req_t  dmi_req_i,
    input  wire logic      dmi_req_valid_i,
    output logic           dmi_req_ready_o,
    output dmi_resp_t      dmi_resp_o,
    output logic           dmi_resp_valid_o,
    input  wire logic      dmi_resp_ready_i
);

    logic [31:0]            sbaddr;
    logic                   sbaddr_load;
    logic                   sbaddr_inc;
    sb_size_e               sb_size;
    mem_req_t               mem_req;
    mem_rsp_t               mem_rsp;
    logic                   rom_req;
    logic [ROM_ADDR_W-1:0]  rom_addr;
    logic [31:0]            rom_rdata;
    logic                   sram_req;
    logic                   sram_we;
    logic [SRAM_ADDR_W-1:0] sram_addr;
    logic [3:0]             sram_be;
    logic [31:0]            sram_wdata;
    logic [31:0]            sram_rdata;

    // ----------------------------------------------------------
    // Debug front end
    // ----------------------------------------------------------
    dm_sba_fsm i_dm_sba_fsm (
        .clk_i            ( clk_i            ),
        .arst_n_i         ( arst_n_i         ),
        .dmi_req_i        ( dmi_req_i        ),
        .dmi_req_valid_i  ( dmi_req_valid_i  ),
        .dmi_req_ready_o  ( dmi_req_ready_o  ),
        .dmi_resp_o       ( dmi_resp_o       ),
        .dmi_resp_valid_o ( dmi_resp_valid_o ),
        .dmi_resp_ready_i ( dmi_resp_ready_i ),
        .sbaddr_i         ( sbaddr           ),
        .sbaddr_load_o    ( sbaddr_load      ),
        .sbaddr_inc_o     ( sbaddr_inc       ),
        .sb_size_o        ( sb_size          ),
        .mem_req_o        ( mem_req          ),
        .mem_rsp_i        ( mem_rsp          )
    );

    // Load strobe only fires on the accepting edge, so request data is valid
    dm_addr_counter i_dm_addr_counter (
        .clk_i       ( clk_i          ),
        .arst_n_i    ( arst_n_i       ),
        .load_i      ( sbaddr_load    ),
        .load_data_i ( dmi_req_i.data ),
        .inc_i       ( sbaddr_inc     ),
        .size_i      ( sb_size        ),
        .addr_o      ( sbaddr         )
    );

    // ----------------------------------------------------------
    // Memory side
    // ----------------------------------------------------------
    mem_xbar i_mem_xbar (
        .clk_i        ( clk_i      ),
        .arst_n_i     ( arst_n_i   ),
        .mem_req_i    ( mem_req    ),
        .mem_rsp_o    ( mem_rsp    ),
        .rom_req_o    ( rom_req    ),
        .rom_addr_o   ( rom_addr   ),
        .rom_rdata_i  ( rom_rdata  ),
        .sram_req_o   ( sram_req   ),
        .sram_we_o    ( sram_we    ),
        .sram_addr_o  ( sram_addr  ),
        .sram_be_o    ( sram_be    ),
        .sram_wdata_o ( sram_wdata ),
        .sram_rdata_i ( sram_rdata )
    );

    boot_rom i_boot_rom (
        .clk_i   ( clk_i     ),
        .req_i   ( rom_req   ),
        .addr_i  ( rom_addr  ),
        .rdata_o ( rom_rdata )
    );

    sram i_sram (
        .clk_i   ( clk_i      ),
        .req_i   ( sram_req   ),
        .we_i    ( sram_we    ),
        .addr_i  ( sram_addr  ),
        .be_i    ( sram_be    ),
        .wdata_i ( sram_wdata ),
        .rdata_o ( sram_rdata )
    );

endmodule

`default_nettype wire

/* mem/mem_xbar.sv */
// Single outstanding access; response follows one cycle after every request
`timescale 1ns/100ps
`default_nettype none

module mem_xbar import dbg_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire mem_req_t               mem_req_i,
    output mem_rsp_t                    mem_rsp_o,
    output logic                        rom_req_o,
    output logic [ROM_ADDR_W-1:0]       rom_addr_o,
    input  wire logic [31:0]            rom_rdata_i,
    output logic                        sram_req_o,
    output logic                        sram_we_o,
    output logic [SRAM_ADDR_W-1:0]      sram_addr_o,
    output logic [3:0]                  sram_be_o,
    output logic [31:0]                 sram_wdata_o,
    input  wire logic [31:0]            sram_rdata_i
);

    logic rom_hit;
    logic sram_hit;
    logic err_d;
    logic rom_sel_q;
    logic sram_sel_q;
    logic err_q;

    // ----------------------------------------------------------
    // Region decode on the byte address
    // ----------------------------------------------------------
    assign rom_hit  = (mem_req_i.addr[31:ROM_ADDR_W+2] == ROM_BASE[31:ROM_ADDR_W+2]);
    assign sram_hit = (mem_req_i.addr[31:SRAM_ADDR_W+2] == SRAM_BASE[31:SRAM_ADDR_W+2]);

    // ROM writes never reach the ROM
    assign rom_req_o  = mem_req_i.req & rom_hit & ~mem_req_i.we;
    assign rom_addr_o = mem_req_i.addr[ROM_ADDR_W+1:2];

    assign sram_req_o   = mem_req_i.req & sram_hit;
    assign sram_we_o    = mem_req_i.we;
    assign sram_addr_o  = mem_req_i.addr[SRAM_ADDR_W+1:2];
    assign sram_be_o    = mem_req_i.be;
    assign sram_wdata_o = mem_req_i.wdata;

    assign err_d = mem_req_i.req & (~(rom_hit | sram_hit) | (rom_hit & mem_req_i.we));

    // Select registered alongside the memory read port
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_sel_q  <= 1'b0;
            sram_sel_q <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            rom_sel_q  <= rom_req_o;
            sram_sel_q <= sram_req_o;
            err_q      <= err_d;
        end
    end

    always_comb begin
        mem_rsp_o.err = err_q;
        if (rom_sel_q)
            mem_rsp_o.rdata = rom_rdata_i;
        else if (sram_sel_q)
            mem_rsp_o.rdata = sram_rdata_i;
        else
            mem_rsp_o.rdata = '0;
    end

endmodule

`default_nettype wire

/* mem/sram.sv */
// Array powers up unknown; read data is not updated by a write
`timescale 1ns/100ps
`default_nettype none

module sram import dbg_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   req_i,
    input  wire logic                   we_i,
    input  wire logic [SRAM_ADDR_W-1:0] addr_i,
    input  wire logic [3:0]             be_i,
    input  wire logic [31:0]            wdata_i,
    output logic [31:0]                 rdata_o
);

    logic [31:0] mem [SRAM_WORDS];
    logic [31:0] rdata_q;

    // ----------------------------------------------------------
    // Single port, byte lanes written independently
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (be_i[i])
                        mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end else begin
                rdata_q <= mem[addr_i];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* mem/boot_rom.sv */
// Contents come from the hex image at start of simulation only
`timescale 1ns/100ps
`default_nettype none

module boot_rom import dbg_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  req_i,
    input  wire logic [ROM_ADDR_W-1:0] addr_i,
    output logic [31:0]                rdata_o
);

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] rdata_q;

    initial begin
        $readmemh(ROM_HEX_FILE, rom);
    end

    // Word held until the next strobe
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_q <= rom[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* dm/dm_sba_fsm.sv */
// One DMI request in flight; SBCS value 3 behaves as a word access on the bus
`timescale 1ns/100ps
`default_nettype none

module dm_sba_fsm import dbg_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire dmi_req_t  dmi_req_i,
    input  wire logic      dmi_req_valid_i,
    output logic           dmi_req_ready_o,
    output dmi_resp_t      dmi_resp_o,
    output logic           dmi_resp_valid_o,
    input  wire logic      dmi_resp_ready_i,
    input  wire logic [31:0] sbaddr_i,
    output logic           sbaddr_load_o,
    output logic           sbaddr_inc_o,
    output sb_size_e       sb_size_o,
    output mem_req_t       mem_req_o,
    input  wire mem_rsp_t  mem_rsp_i
);

    dm_state_e   state_q, state_d;
    sb_size_e    sbcs_q, sbcs_d;
    logic        we_q, we_d;
    logic [31:0] data_q, data_d;
    dmi_resp_t   resp_q, resp_d;

    logic        misaligned;
    logic [3:0]  be;
    logic [31:0] wdata_rep;
    logic [31:0] rdata_shift;
    logic [31:0] rdata_ext;

    // ----------------------------------------------------------
    // Lane handling from size and low address bits
    // ----------------------------------------------------------
    always_comb begin
        rdata_shift = mem_rsp_i.rdata >> {sbaddr_i[1:0], 3'b000};
        case (sbcs_q)
            BYTE: begin
                misaligned = 1'b0;
                be         = 4'b0001 << sbaddr_i[1:0];
                wdata_rep  = {4{data_q[7:0]}};
                rdata_ext  = {24'h0, rdata_shift[7:0]};
            end
            HALF: begin
                misaligned = sbaddr_i[0];
                be         = 4'b0011 << {sbaddr_i[1], 1'b0};
                wdata_rep  = {2{data_q[15:0]}};
                rdata_ext  = {16'h0, rdata_shift[15:0]};
            end
            default: begin
                misaligned = |sbaddr_i[1:0];
                be         = 4'b1111;
                wdata_rep  = data_q;
                rdata_ext  = mem_rsp_i.rdata;
            end
        endcase
    end

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        state_d       = state_q;
        sbcs_d        = sbcs_q;
        we_d          = we_q;
        data_d        = data_q;
        resp_d        = resp_q;
        sbaddr_load_o = 1'b0;
        sbaddr_inc_o  = 1'b0;

        case (state_q)
            IDLE: begin
                if (dmi_req_valid_i) begin
                    // Default answer, overridden per register below
                    resp_d.resp = SUCCESS;
                    resp_d.data = '0;
                    state_d     = RESP;
                    case (dmi_req_i.op)
                        NOP: ;
                        READ, WRITE: begin
                            case (dmi_req_i.addr)
                                DM_SBCS_ADDR: begin
                                    if (dmi_req_i.op == WRITE)
                                        sbcs_d = sb_size_e'(dmi_req_i.data[1:0]);
                                    else
                                        resp_d.data = {30'h0, sbcs_q};
                                end
                                DM_SBADDR_ADDR: begin
                                    if (dmi_req_i.op == WRITE)
                                        sbaddr_load_o = 1'b1;
                                    else
                                        resp_d.data = sbaddr_i;
                                end
                                DM_SBDATA_ADDR: begin
                                    if (misaligned) begin
                                        resp_d.resp = FAILED;
                                    end else begin
                                        we_d    = (dmi_req_i.op == WRITE);
                                        data_d  = dmi_req_i.data;
                                        state_d = BUS_REQ;
                                    end
                                end
                                default: resp_d.resp = FAILED;
                            endcase
                        end
                        // Reserved op code
                        default: resp_d.resp = FAILED;
                    endcase
                end
            end
            BUS_REQ: state_d = BUS_WAIT;
            BUS_WAIT: begin
                // Read data and err arrive one cycle after the strobe
                if (mem_rsp_i.err) begin
                    resp_d.resp = FAILED;
                    resp_d.data = '0;
                end else begin
                    resp_d.resp  = SUCCESS;
                    resp_d.data  = we_q ? 32'h0 : rdata_ext;
                    sbaddr_inc_o = 1'b1;
                end
                state_d = RESP;
            end
            default: begin
                if (dmi_resp_ready_i)
                    state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            sbcs_q  <= WORD;
            we_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            sbcs_q  <= sbcs_d;
            we_q    <= we_d;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q <= data_d;
        resp_q <= resp_d;
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------
    assign dmi_req_ready_o  = (state_q == IDLE);
    assign dmi_resp_valid_o = (state_q == RESP);
    assign dmi_resp_o       = resp_q;
    assign sb_size_o        = sbcs_q;

    always_comb begin
        mem_req_o.req   = (state_q == BUS_REQ);
        mem_req_o.we    = we_q;
        mem_req_o.addr  = sbaddr_i;
        mem_req_o.be    = be;
        mem_req_o.wdata = wdata_rep;
    end

endmodule

`default_nettype wire

/* dm/dm_addr_counter.sv */
// Load wins over increment; sizes other than byte and half step by four
`timescale 1ns/100ps
`default_nettype none

module dm_addr_counter import dbg_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        load_i,
    input  wire logic [31:0] load_data_i,
    input  wire logic        inc_i,
    input  wire sb_size_e    size_i,
    output logic [31:0]      addr_o
);

    logic [31:0] addr_q;
    logic [31:0] step;

    // Step equals the access size in bytes
    always_comb begin
        case (size_i)
            BYTE:    step = 32'd1;
            HALF:    step = 32'd2;
            default: step = 32'd4;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q <= '0;
        end else if (load_i) begin
            addr_q <= load_data_i;
        end else if (inc_i) begin
            addr_q <= addr_q + step;
        end
    end

    assign addr_o = addr_q;

endmodule

`default_nettype wire

/* common/dbg_pkg.sv */
// Fixed memory map and DMI encodings; BUSY (2'd3) is reserved and never produced
`default_nettype none

package dbg_pkg;

    // ----------------------------------------------------------
    // Debug module register addresses
    // ----------------------------------------------------------
    localparam logic [6:0] DM_SBCS_ADDR   = 7'h38;
    localparam logic [6:0] DM_SBADDR_ADDR = 7'h39;
    localparam logic [6:0] DM_SBDATA_ADDR = 7'h3C;

    // ----------------------------------------------------------
    // Memory map
    // ----------------------------------------------------------
    localparam logic [31:0] ROM_BASE    = 32'h0000_1000;
    localparam int unsigned ROM_WORDS   = 16;
    localparam int unsigned ROM_ADDR_W  = $clog2(ROM_WORDS);
    localparam logic [31:0] SRAM_BASE   = 32'h8000_0000;
    localparam int unsigned SRAM_WORDS  = 256;
    localparam int unsigned SRAM_ADDR_W = $clog2(SRAM_WORDS);

    // Boot image, relative to the simulation directory
    localparam string ROM_HEX_FILE = "mem/boot.hex";

    // ----------------------------------------------------------
    // Enumerations
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        NOP   = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2
    } dmi_op_e;

    // Code 3 would be BUSY
    typedef enum logic [1:0] {
        SUCCESS = 2'd0,
        FAILED  = 2'd2
    } dmi_resp_e;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } sb_size_e;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        BUS_REQ  = 2'd1,
        BUS_WAIT = 2'd2,
        RESP     = 2'd3
    } dm_state_e;

    // ----------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------
    typedef struct packed {
        logic [6:0]  addr;
        dmi_op_e     op;
        logic [31:0] data;
    } dmi_req_t;

    typedef struct packed {
        dmi_resp_e   resp;
        logic [31:0] data;
    } dmi_resp_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } mem_rsp_t;

endpackage

`default_nettype wire
